// ==== cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path and address bus width
`define CPU_WIDTH 8

// SP after reset, first PUSH wraps to the top byte
`define CPU_STACK_RESET 8'h00

// All ones but bit 0
`define CPU_NOP_BYTE 8'hfe

`endif

// ==== cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

  typedef logic [`CPU_WIDTH-1:0] cpu_byte_t;

  // Instruction cycle
  typedef enum logic [2:0] {
    FETCH_OPCODE,
    DECODE,
    FETCH_OPERANDS,
    EXECUTE,
    WRITE_REGISTER,
    WRITE_MEMORY,
    HALTED
  } cpu_stage_t;

  typedef enum logic [2:0] {
    MOV,
    ADD,
    JMP,
    PUSH,
    POP,
    NOP,
    HLT
  } cpu_opcode_t;

  typedef enum logic [2:0] {
    OPERAND_NONE,
    REG_A,
    REG_SP,
    ADDR_REG_A,  // Memory at A
    ADDR_REG_SP, // Memory at SP
    ADDR_IMM,    // Memory at an immediate address
    IMM
  } cpu_operand_t;

endpackage

// ==== cpu_sequencer.sv ====
`timescale 1ns/1ps

module cpu_sequencer (
  input  logic                  CLOCK,
  input  logic                  RESET,
  input  logic                  fetch_done,
  input  cpu_pkg::cpu_opcode_t  decode_opcode,
  input  cpu_pkg::cpu_operand_t decode_dst,
  output cpu_pkg::cpu_stage_t   stage,
  output logic                  halted
);
  import cpu_pkg::*;

  cpu_stage_t next_stage;
  logic       dst_in_memory;

  assign dst_in_memory = decode_dst inside {ADDR_REG_A, ADDR_REG_SP, ADDR_IMM};

  always_comb begin
    next_stage = stage;
    case (stage)
      FETCH_OPCODE: begin
        if (fetch_done) next_stage = DECODE;
      end
      DECODE:         next_stage = FETCH_OPERANDS;
      FETCH_OPERANDS: begin
        if (fetch_done) next_stage = EXECUTE;
      end
      EXECUTE: begin
        if (decode_opcode == HLT) next_stage = HALTED; // Illegal bytes decode as HLT
        else next_stage = WRITE_REGISTER;
      end
      WRITE_REGISTER: begin
        if (dst_in_memory) next_stage = WRITE_MEMORY;
        else next_stage = FETCH_OPCODE;
      end
      WRITE_MEMORY: begin
        if (fetch_done) next_stage = FETCH_OPCODE;
      end
      default:        next_stage = HALTED; // Only reset leaves
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage  <= FETCH_OPCODE;
      halted <= 1'b0;
    end else begin
      stage  <= next_stage;
      halted <= (next_stage == HALTED);
    end
  end

endmodule

// ==== cpu_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_decoder (
  input  logic                  CLOCK,
  input  logic                  RESET,
  input  cpu_pkg::cpu_stage_t   stage,
  input  cpu_pkg::cpu_byte_t    opcode_byte,
  output cpu_pkg::cpu_opcode_t  decode_opcode,
  output cpu_pkg::cpu_operand_t decode_src,
  output cpu_pkg::cpu_operand_t decode_dst
);
  import cpu_pkg::*;

  cpu_opcode_t  next_opcode;
  cpu_operand_t next_src;
  cpu_operand_t next_dst;

  // Three-bit operand field of MOV, ADD, PUSH and POP
  function automatic cpu_operand_t field_kind(input logic [2:0] code);
    case (code)
      3'd0:       return REG_A;
      3'd1:       return ADDR_REG_A;
      3'd2, 3'd6: return ADDR_IMM;
      3'd4:       return REG_SP;
      3'd5:       return ADDR_REG_SP;
      default:    return IMM;
    endcase
  endfunction

  always_comb begin
    next_opcode = HLT;
    next_src    = OPERAND_NONE;
    next_dst    = OPERAND_NONE;
    casez (opcode_byte)
      8'b0???????: begin
        if (opcode_byte[4:3] != 2'b11) begin // Immediate destination is illegal
          if (opcode_byte[6]) next_opcode = ADD;
          else next_opcode = MOV;
          next_dst = field_kind(opcode_byte[5:3]);
          next_src = field_kind(opcode_byte[2:0]);
        end
      end
      8'b1100????: begin
        next_opcode = JMP;
        next_src    = IMM; // Signed offset
      end
      8'b111?00??: begin
        next_opcode = PUSH;
        next_src    = field_kind({opcode_byte[4], opcode_byte[1:0]});
        next_dst    = ADDR_REG_SP;
      end
      8'b111?010?: begin
        next_opcode = POP;
        next_src    = ADDR_REG_SP;
        next_dst    = field_kind({opcode_byte[4], 1'b0, opcode_byte[0]});
      end
      default: begin
        if (opcode_byte == `CPU_NOP_BYTE) next_opcode = NOP;
      end
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      decode_opcode <= NOP;
      decode_src    <= OPERAND_NONE;
      decode_dst    <= OPERAND_NONE;
    end else if (stage == DECODE) begin
      decode_opcode <= next_opcode;
      decode_src    <= next_src;
      decode_dst    <= next_dst;
    end
  end

endmodule

// ==== cpu_access_unit.sv ====
`timescale 1ns/1ps

module cpu_access_unit (
  input  logic                  CLOCK,
  input  logic                  RESET,
  input  cpu_pkg::cpu_stage_t   stage,
  input  cpu_pkg::cpu_opcode_t  decode_opcode,
  input  cpu_pkg::cpu_operand_t decode_src,
  input  cpu_pkg::cpu_operand_t decode_dst,
  input  cpu_pkg::cpu_byte_t    reg_a,
  input  cpu_pkg::cpu_byte_t    reg_sp,
  input  logic                  access_done,
  input  cpu_pkg::cpu_byte_t    access_rdata,
  output logic                  access_start,
  output logic                  access_write,
  output cpu_pkg::cpu_byte_t    access_addr,
  output logic                  fetch_done,
  output cpu_pkg::cpu_byte_t    imm,
  output cpu_pkg::cpu_byte_t    mem_src,
  output cpu_pkg::cpu_byte_t    mem_dst
);
  import cpu_pkg::*;

  // Operand fetch order
  typedef enum logic [2:0] {
    STEP_IDLE,
    STEP_IMM,
    STEP_SRC_ADDR,
    STEP_SRC,
    STEP_DST_ADDR,
    STEP_DST
  } step_t;

  cpu_stage_t prev_stage;
  step_t      step;
  step_t      step_next;
  cpu_byte_t  ip;
  cpu_byte_t  src_addr;
  cpu_byte_t  dst_addr;
  logic       entered;
  logic       start_next;
  logic       done_next;
  logic       ip_byte_done;

  function automatic logic is_memory(input cpu_operand_t kind);
    return kind inside {ADDR_REG_A, ADDR_REG_SP, ADDR_IMM};
  endfunction

  // Next step the instruction needs after the given one
  function automatic step_t following(input step_t from);
    step_t found;
    found = STEP_IDLE;
    if (is_memory(decode_dst) && from < STEP_DST) found = STEP_DST;
    if (decode_dst == ADDR_IMM && from < STEP_DST_ADDR) found = STEP_DST_ADDR;
    if (is_memory(decode_src) && from < STEP_SRC) found = STEP_SRC;
    if (decode_src == ADDR_IMM && from < STEP_SRC_ADDR) found = STEP_SRC_ADDR;
    if (decode_src == IMM && from < STEP_IMM) found = STEP_IMM;
    return found;
  endfunction

  function automatic cpu_byte_t operand_addr(input cpu_operand_t kind,
                                             input cpu_byte_t latched,
                                             input logic below_sp);
    case (kind)
      ADDR_REG_A:  return reg_a;
      ADDR_REG_SP: return below_sp ? reg_sp - 1'b1 : reg_sp;
      default:     return latched;
    endcase
  endfunction

  assign entered      = (stage != prev_stage);
  assign access_write = (stage == WRITE_MEMORY);
  assign ip_byte_done = access_done &&
                        (stage == FETCH_OPCODE ||
                         step inside {STEP_IMM, STEP_SRC_ADDR, STEP_DST_ADDR});

  always_comb begin
    step_next  = step;
    start_next = 1'b0;
    done_next  = 1'b0;
    case (stage)
      FETCH_OPCODE, WRITE_MEMORY: begin
        start_next = entered; // One access per stage
        done_next  = access_done;
      end
      FETCH_OPERANDS: begin
        if (entered || access_done) begin
          step_next  = following(step);
          start_next = (step_next != STEP_IDLE);
          done_next  = (step_next == STEP_IDLE);
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    access_addr = ip;
    case (stage)
      FETCH_OPERANDS: begin
        if (step == STEP_SRC) access_addr = operand_addr(decode_src, src_addr, 1'b0);
        if (step == STEP_DST) access_addr = operand_addr(decode_dst, dst_addr,
                                                         decode_opcode == PUSH);
      end
      WRITE_MEMORY: access_addr = dst_addr;
      default: ;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      prev_stage   <= HALTED; // First cycle after reset counts as entry to the fetch
      step         <= STEP_IDLE;
      ip           <= '0;
      access_start <= 1'b0;
      fetch_done   <= 1'b0;
    end else begin
      prev_stage   <= stage;
      step         <= step_next;
      access_start <= start_next;
      fetch_done   <= done_next;
      if (stage == EXECUTE && decode_opcode == JMP) ip <= ip + imm; // Relative to next opcode
      else if (ip_byte_done) ip <= ip + 1'b1;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (access_done) begin
      case (step)
        STEP_IMM:      imm      <= access_rdata;
        STEP_SRC_ADDR: src_addr <= access_rdata;
        STEP_SRC:      mem_src  <= access_rdata;
        STEP_DST_ADDR: dst_addr <= access_rdata;
        STEP_DST: begin
          mem_dst  <= access_rdata;
          dst_addr <= access_addr; // Effective address, reused by the write
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== cpu_memory_port.sv ====
`timescale 1ns/1ps

module cpu_memory_port (
  input  logic               CLOCK,
  input  logic               RESET,
  input  logic               access_start,
  input  logic               access_write,
  input  cpu_pkg::cpu_byte_t access_addr,
  input  cpu_pkg::cpu_byte_t wdata,
  output logic               access_done,
  output cpu_pkg::cpu_byte_t access_rdata,
  output logic               mem_req,
  output logic               mem_we,
  output cpu_pkg::cpu_byte_t mem_addr,
  output cpu_pkg::cpu_byte_t mem_wdata,
  input  logic               mem_ack,
  input  cpu_pkg::cpu_byte_t mem_rdata
);

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_REQUEST,
    PORT_RELEASE, // Waiting for ack to fall
    PORT_DONE
  } port_state_t;

  port_state_t state;
  logic        write_q;

  assign mem_req     = (state == PORT_REQUEST);
  assign mem_we      = mem_req && write_q;
  assign access_done = (state == PORT_DONE);

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      state <= PORT_IDLE;
    end else begin
      case (state)
        PORT_IDLE:    if (access_start) state <= PORT_REQUEST;
        PORT_REQUEST: if (mem_ack) state <= PORT_RELEASE;
        PORT_RELEASE: if (!mem_ack) state <= PORT_DONE;
        default:      state <= PORT_IDLE;
      endcase
    end
  end

  // Bus fields stay frozen until the next start
  always_ff @(posedge CLOCK) begin
    if (state == PORT_IDLE && access_start) begin
      mem_addr  <= access_addr;
      mem_wdata <= wdata;
      write_q   <= access_write;
    end
    if (state == PORT_REQUEST && mem_ack) access_rdata <= mem_rdata;
  end

endmodule

// ==== cpu_execute.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_execute (
  input  logic                  CLOCK,
  input  logic                  RESET,
  input  cpu_pkg::cpu_stage_t   stage,
  input  cpu_pkg::cpu_opcode_t  decode_opcode,
  input  cpu_pkg::cpu_operand_t decode_src,
  input  cpu_pkg::cpu_operand_t decode_dst,
  input  cpu_pkg::cpu_byte_t    imm,
  input  cpu_pkg::cpu_byte_t    mem_src,
  input  cpu_pkg::cpu_byte_t    mem_dst,
  output cpu_pkg::cpu_byte_t    result,
  output cpu_pkg::cpu_byte_t    reg_a,
  output cpu_pkg::cpu_byte_t    reg_sp
);
  import cpu_pkg::*;

  cpu_byte_t src_value;
  cpu_byte_t dst_value;

  function automatic cpu_byte_t operand_value(input cpu_operand_t kind,
                                              input cpu_byte_t memory,
                                              input cpu_byte_t a,
                                              input cpu_byte_t sp,
                                              input cpu_byte_t immediate);
    case (kind)
      REG_A:                             return a;
      REG_SP:                            return sp;
      IMM:                               return immediate;
      ADDR_REG_A, ADDR_REG_SP, ADDR_IMM: return memory;
      default:                           return '0;
    endcase
  endfunction

  always_comb begin
    src_value = operand_value(decode_src, mem_src, reg_a, reg_sp, imm);
    dst_value = operand_value(decode_dst, mem_dst, reg_a, reg_sp, imm); // Old destination
  end

  // ALU
  always_ff @(posedge CLOCK) begin
    if (stage == EXECUTE) begin
      if (decode_opcode == ADD) result <= dst_value + src_value;
      else result <= src_value;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      reg_a  <= '0;
      reg_sp <= `CPU_STACK_RESET;
    end else if (stage == WRITE_REGISTER) begin
      if (decode_dst == REG_A) reg_a <= result;
      if (decode_dst == REG_SP) begin
        reg_sp <= result;
      end else if (decode_opcode == PUSH) begin
        reg_sp <= reg_sp - 1'b1;
      end else if (decode_opcode == POP) begin
        reg_sp <= reg_sp + 1'b1;
      end
    end
  end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
  input  logic               CLOCK,
  input  logic               RESET,
  input  logic               mem_ack,
  input  cpu_pkg::cpu_byte_t mem_rdata,
  output logic               mem_req,
  output logic               mem_we,
  output cpu_pkg::cpu_byte_t mem_addr,
  output cpu_pkg::cpu_byte_t mem_wdata,
  output cpu_pkg::cpu_byte_t reg_a,
  output logic               halted
);
  import cpu_pkg::*;

  cpu_stage_t   stage;
  cpu_opcode_t  decode_opcode;
  cpu_operand_t decode_src;
  cpu_operand_t decode_dst;
  cpu_byte_t    reg_sp;
  cpu_byte_t    imm;
  cpu_byte_t    mem_src;
  cpu_byte_t    mem_dst;
  cpu_byte_t    result;
  logic         fetch_done;
  logic         access_start;
  logic         access_write;
  cpu_byte_t    access_addr;
  logic         access_done;
  cpu_byte_t    access_rdata;

  cpu_sequencer u_sequencer (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .fetch_done    (fetch_done),
    .decode_opcode (decode_opcode),
    .decode_dst    (decode_dst),
    .stage         (stage),
    .halted        (halted)
  );

  // Port still holds the opcode byte while in DECODE
  cpu_decoder u_decoder (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .stage         (stage),
    .opcode_byte   (access_rdata),
    .decode_opcode (decode_opcode),
    .decode_src    (decode_src),
    .decode_dst    (decode_dst)
  );

  cpu_access_unit u_access_unit (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .stage         (stage),
    .decode_opcode (decode_opcode),
    .decode_src    (decode_src),
    .decode_dst    (decode_dst),
    .reg_a         (reg_a),
    .reg_sp        (reg_sp),
    .access_done   (access_done),
    .access_rdata  (access_rdata),
    .access_start  (access_start),
    .access_write  (access_write),
    .access_addr   (access_addr),
    .fetch_done    (fetch_done),
    .imm           (imm),
    .mem_src       (mem_src),
    .mem_dst       (mem_dst)
  );

  cpu_memory_port u_memory_port (
    .CLOCK        (CLOCK),
    .RESET        (RESET),
    .access_start (access_start),
    .access_write (access_write),
    .access_addr  (access_addr),
    .wdata        (result),
    .access_done  (access_done),
    .access_rdata (access_rdata),
    .mem_req      (mem_req),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ack      (mem_ack),
    .mem_rdata    (mem_rdata)
  );

  cpu_execute u_execute (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .stage         (stage),
    .decode_opcode (decode_opcode),
    .decode_src    (decode_src),
    .decode_dst    (decode_dst),
    .imm           (imm),
    .mem_src       (mem_src),
    .mem_dst       (mem_dst),
    .result        (result),
    .reg_a         (reg_a),
    .reg_sp        (reg_sp)
  );

endmodule

// ==== tb_cpu_checker.sv ====
`timescale 1ns/1ps

module tb_cpu_checker (
  input logic               CLOCK,
  input logic               RESET,
  input logic               mem_req,
  input logic               mem_ack,
  input logic               mem_we,
  input cpu_pkg::cpu_byte_t mem_addr,
  input cpu_pkg::cpu_byte_t mem_wdata,
  input logic               halted
);

  int unsigned failures = 0; // Failed assertions so far

  req_held_until_ack: assert property (
    @(posedge CLOCK) disable iff (RESET)
    mem_req && !mem_ack |=> mem_req
  ) else begin
    $error("mem_req fell before mem_ack rose");
    failures++;
  end

  // Address, direction and data frozen for the whole request
  bus_fields_stable: assert property (
    @(posedge CLOCK) disable iff (RESET)
    $past(mem_req) && mem_req |-> $stable(mem_addr) && $stable(mem_we) && $stable(mem_wdata)
  ) else begin
    $error("memory bus fields changed while mem_req was high");
    failures++;
  end

  no_req_when_halted: assert property (
    @(posedge CLOCK) disable iff (RESET)
    halted |-> !$rose(mem_req)
  ) else begin
    $error("mem_req rose while the CPU was halted");
    failures++;
  end

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;
  import cpu_pkg::*;

  logic      CLOCK;
  logic      RESET;
  logic      mem_ack;
  cpu_byte_t mem_rdata;
  logic      mem_req;
  logic      mem_we;
  cpu_byte_t mem_addr;
  cpu_byte_t mem_wdata;
  cpu_byte_t reg_a;
  logic      halted;

  cpu_byte_t   mem [256];
  cpu_byte_t   model_mem [256];
  cpu_byte_t   program_q [$];
  logic [15:0] data_q [$];          // {address, byte} placed after the program
  logic [15:0] expected_writes [$]; // {address, byte} in bus order
  cpu_byte_t   expected_a;
  cpu_byte_t   expected_halt;
  cpu_byte_t   last_addr;
  int          model_steps;
  string       test_name = "reset";
  time         deadline = 100000;
  logic [15:0] lfsr = 16'd64585;
  logic        req_seen = 1'b0;
  logic        first_request = 1'b0;
  logic [15:0] write_expected;

  cpu_top u_cpu_top (.*);

  bind cpu_top tb_cpu_checker u_checker (
    .CLOCK     (CLOCK),
    .RESET     (RESET),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .halted    (halted)
  );

  always #10 CLOCK = ~CLOCK;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "stopping at the first failure");
  endtask

  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) return (state >> 1) ^ 16'hb400;
    return state >> 1;
  endfunction

  // Instruction set model over model_mem
  function automatic void run_model();
    cpu_byte_t   ip, a, sp, op, s_val, d_val, d_addr, res;
    logic [2:0]  s_code, d_code;
    cpu_opcode_t kind;
    logic        d_mem, running;
    ip = '0;
    a = '0;
    sp = `CPU_STACK_RESET;
    running = 1'b1;
    model_steps = 0;
    expected_writes.delete();
    while (running && model_steps < 1000) begin
      op = model_mem[ip];
      ip = ip + 1'b1;
      model_steps++;
      s_code = op[2:0];
      d_code = op[5:3];
      kind = HLT;
      if (!op[7] && op[4:3] != 2'b11) kind = op[6] ? ADD : MOV;
      else if (op[7:4] == 4'b1100) kind = JMP;
      else if (op[7:5] == 3'b111 && op[3:2] == 2'b00) begin
        kind = PUSH;
        s_code = {op[4], op[1:0]};
      end else if (op[7:5] == 3'b111 && op[3:1] == 3'b010) begin
        kind = POP;
        d_code = {op[4], 1'b0, op[0]};
      end else if (op == `CPU_NOP_BYTE) kind = NOP;
      case (kind)
        HLT: begin
          running = 1'b0;
          expected_halt = ip - 1'b1; // Address of the halting opcode
        end
        JMP: ip = ip + 1'b1 + model_mem[ip]; // Offset counts from the next opcode
        MOV, ADD, PUSH, POP: begin
          if (kind == POP) s_val = model_mem[sp];
          else begin
            case (s_code)
              3'd0: s_val = a;
              3'd4: s_val = sp;
              3'd1: s_val = model_mem[a];
              3'd5: s_val = model_mem[sp];
              3'd2, 3'd6: begin
                s_val = model_mem[model_mem[ip]];
                ip = ip + 1'b1;
              end
              default: begin
                s_val = model_mem[ip];
                ip = ip + 1'b1;
              end
            endcase
          end
          d_mem = 1'b1;
          d_addr = sp - 1'b1; // PUSH target
          if (kind != PUSH) begin
            case (d_code)
              3'd1: d_addr = a;
              3'd5: d_addr = sp;
              3'd2, 3'd6: begin
                d_addr = model_mem[ip];
                ip = ip + 1'b1;
              end
              default: d_mem = 1'b0;
            endcase
          end
          d_val = d_mem ? model_mem[d_addr] : (d_code == 3'd4 ? sp : a);
          res = (kind == ADD) ? d_val + s_val : s_val;
          if (d_mem) begin
            model_mem[d_addr] = res;
            expected_writes.push_back({d_addr, res});
          end
          if (!d_mem && d_code == 3'd4) sp = res;
          else begin
            if (!d_mem) a = res;
            if (kind == PUSH) sp = sp - 1'b1;
            if (kind == POP) sp = sp + 1'b1;
          end
        end
        default: ;
      endcase
    end
    expected_a = a;
  endfunction

  task automatic run_test(input string name);
    int i;
    test_name = name;
    @(negedge CLOCK);
    RESET = 1'b1;
    for (i = 0; i < 256; i++) mem[i] = 8'(i * 29 + 101);
    foreach (program_q[j]) mem[j] = program_q[j];
    foreach (data_q[j]) mem[data_q[j][15:8]] = data_q[j][7:0];
    model_mem = mem;
    run_model();
    deadline = $time + (model_steps * 6 * 10 + 160) * 20;
    repeat (4) @(negedge CLOCK);
    RESET = 1'b0;
    @(negedge CLOCK);
    assert (mem_req === 1'b0 && halted === 1'b0) else
      report_failure($sformatf("error %s: after reset expected req 0 halted 0, actual %b %b",
                               name, mem_req, halted));
    while (halted !== 1'b1) @(negedge CLOCK);
    assert (reg_a === expected_a) else
      report_failure($sformatf("error %s: final A expected %h, actual %h",
                               name, expected_a, reg_a));
    // Last request is the fetch of the halting opcode
    assert (last_addr === expected_halt) else
      report_failure($sformatf("error %s: halt point expected %h, actual %h",
                               name, expected_halt, last_addr));
    assert (expected_writes.size() == 0) else
      report_failure($sformatf("%s: %0d expected memory writes never happened",
                               name, expected_writes.size()));
    repeat (50) @(negedge CLOCK); // Quiet bus after halt
    assert (halted === 1'b1) else
      report_failure($sformatf("%s: halted dropped without a reset", name));
  endtask

  // Answers each request after 0 to 7 cycles
  initial begin : memory_model
    logic [2:0] delay;
    int         bit_index;
    mem_ack = 1'b0;
    mem_rdata = '0;
    forever begin
      @(negedge CLOCK);
      if (mem_req === 1'b1) begin
        for (bit_index = 0; bit_index < 3; bit_index++) begin
          lfsr = lfsr_step(lfsr);
          delay = {delay[1:0], lfsr[0]};
        end
        repeat (delay) @(negedge CLOCK);
        if (mem_we) mem[mem_addr] = mem_wdata;
        else mem_rdata = mem[mem_addr];
        mem_ack = 1'b1;
        while (mem_req === 1'b1) @(negedge CLOCK);
        mem_ack = 1'b0;
      end
    end
  end

  // Checks each new request against the model
  always @(negedge CLOCK) begin
    assert (u_cpu_top.u_checker.failures == 0) else
      report_failure($sformatf("%s: a bus handshake assertion failed", test_name));
    if (RESET === 1'b1) first_request = 1'b1;
    if (RESET === 1'b0 && mem_req === 1'b1 && !req_seen) begin
      last_addr = mem_addr;
      assert (halted !== 1'b1) else
        report_failure($sformatf("%s: memory request issued after halt", test_name));
      if (first_request) begin
        assert (!mem_we && mem_addr == 8'h00) else
          report_failure($sformatf(
              "error %s: first request expected read at 00, actual we %b at %h",
              test_name, mem_we, mem_addr));
        first_request = 1'b0;
      end
      if (mem_we) begin
        assert (expected_writes.size() > 0) else
          report_failure($sformatf("%s: unexpected write of %h to %h",
                                   test_name, mem_wdata, mem_addr));
        write_expected = expected_writes.pop_front();
        assert ({mem_addr, mem_wdata} == write_expected) else
          report_failure($sformatf("error %s: write expected %h, actual %h",
                                   test_name, write_expected, {mem_addr, mem_wdata}));
      end
    end
    req_seen = (mem_req === 1'b1);
  end

  initial begin : watchdog
    forever begin
      @(posedge CLOCK);
      if ($time > deadline)
        report_failure($sformatf("%s: timeout, the CPU did not halt in time", test_name));
    end
  end

  initial begin
    CLOCK = 1'b0;
    RESET = 1'b1;
    program_q = '{8'h03, 8'h12, 8'h43, 8'h34, 8'h20, 8'h44, 8'h63, 8'h05,
                  8'h40, 8'h44, 8'hfe, 8'hff};
    data_q.delete();
    run_test("reg_imm");
    program_q = '{8'h03, 8'h80, 8'h0b, 8'h11, 8'h4b, 8'h22, 8'h11, 8'h90, 8'h23,
                  8'h90, 8'h68, 8'h42, 8'h40, 8'h12, 8'h90, 8'ha0, 8'h45, 8'hff};
    run_test("mem_operands");
    program_q = '{8'h03, 8'h5a, 8'he0, 8'he3, 8'h3c, 8'he4, 8'he5, 8'hf0,
                  8'h42, 8'h3c, 8'hf5, 8'hff};
    run_test("stack");
    // Loop rewrites its own JMP offset from a table at 60
    program_q = '{8'h03, 8'h5f, 8'hc0, 8'h02, 8'h43, 8'h40, 8'h43, 8'h01,
                  8'h11, 8'h0d, 8'h10, 8'h70, 8'hc0, 8'h00, 8'hff};
    data_q = '{16'h60f8, 16'h61f8, 16'h62f8, 16'h6300};
    run_test("jumps");
    program_q = '{8'h03, 8'h77, 8'hfe, 8'h1b, 8'hff}; // 1b has an immediate destination
    data_q.delete();
    run_test("illegal");
    if (u_cpu_top.u_checker.failures == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      report_failure("a bus handshake assertion failed at the end of the run");
    end
  end

endmodule

// ==== sources.f ====
+incdir+.
cpu_pkg.sv
cpu_sequencer.sv
cpu_decoder.sv
cpu_access_unit.sv
cpu_memory_port.sv
cpu_execute.sv
cpu_top.sv
tb_cpu_checker.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: accumulator_cpu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - cpu_sequencer.sv
      - cpu_decoder.sv
      - cpu_access_unit.sv
      - cpu_memory_port.sv
      - cpu_execute.sv
      - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu_checker.sv
      - tb_cpu.sv
